//--- verilog/core_mem_consts.svh
`ifndef CORE_MEM_CONSTS_SVH
`define CORE_MEM_CONSTS_SVH

// ==============================
// Address and data widths
// ==============================
`define ADDR_W 32
`define WORD_W 32

// ==============================
// Memory line geometry
// ==============================
`define LINE_BYTES 16
`define LINE_W (`LINE_BYTES * 8)

// Addressable memory size where the PC wraps
`define MEM_BYTES 4096

// First fetch address
`define RESET_PC 32'h0000_0000

`endif

//--- verilog/core_mem_pkg.sv
`include "core_mem_consts.svh"

package core_mem_pkg;

  // ==============================
  // Data types
  // ==============================
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`LINE_W-1:0] line_t;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } access_size_t;

  // ==============================
  // State machines
  // ==============================
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_INSTR,
    ARB_DATA
  } arb_state_t;

  typedef enum logic [1:0] {
    FETCH_RUN,
    FETCH_REQ,
    FETCH_WAIT
  } fetch_state_t;

  typedef enum logic [2:0] {
    LSU_IDLE,
    LSU_RD_REQ,
    LSU_RD_WAIT,
    LSU_WR_REQ,
    LSU_WR_WAIT
  } lsu_state_t;

endpackage

//--- verilog/mem_req_if.sv
`timescale 1ns/10ps

interface mem_req_if import core_mem_pkg::*; ();

  // Requester holds these until gnt
  logic  req;
  logic  we;
  addr_t addr;
  line_t wdata;

  // Driven by the arbiter
  logic  gnt;
  line_t rdata;
  logic  rvalid;
  logic  wdone;

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata,
    input  rvalid,
    input  wdone
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata,
    output rvalid,
    output wdone
  );

endinterface

//--- verilog/fetch_unit.sv
`timescale 1ns/10ps
`include "core_mem_consts.svh"

module fetch_unit import core_mem_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  fetch_en_i,
  input  logic  redirect_i,
  input  addr_t redirect_pc_i,
  output logic  instr_valid_o,
  output word_t instr_o,
  output addr_t instr_pc_o,
  mem_req_if.requester bus
);

  localparam int OFF_W  = $clog2(`LINE_BYTES);
  localparam int WOFF_W = $clog2(`WORD_W / 8);
  localparam int IDX_W  = OFF_W - WOFF_W;
  localparam int TAG_W  = `ADDR_W - OFF_W;

  fetch_state_t     state_q;
  addr_t            pc_q;
  addr_t            pc_d;
  addr_t            req_addr_q;
  line_t            buf_line_q;
  logic [TAG_W-1:0] buf_tag_q;
  logic             buf_valid_q;
  logic             stale_q;
  logic             req_q;
  logic             buf_hit;
  logic             next_hit;
  logic             issue;
  logic             fill;
  logic [IDX_W-1:0] word_idx;

  // ==============================
  // Instruction delivery
  // ==============================
  assign word_idx      = pc_q[OFF_W-1:WOFF_W];
  assign buf_hit       = buf_valid_q && (buf_tag_q == pc_q[`ADDR_W-1:OFF_W]);
  assign instr_valid_o = fetch_en_i && buf_hit && !redirect_i;
  assign instr_o       = buf_line_q[word_idx*`WORD_W +: `WORD_W];
  assign instr_pc_o    = pc_q;

  always_comb begin
    if (redirect_i) begin
      pc_d = addr_t'(redirect_pc_i % `MEM_BYTES);
    end else if (instr_valid_o) begin
      pc_d = addr_t'((pc_q + (`WORD_W / 8)) % `MEM_BYTES);
    end else begin
      pc_d = pc_q;
    end
  end

  // Look ahead at the next PC so the request leaves one cycle after the change
  assign next_hit = buf_valid_q && (buf_tag_q == pc_d[`ADDR_W-1:OFF_W]);
  assign issue    = (state_q == FETCH_RUN) && !next_hit;
  assign fill     = (state_q == FETCH_WAIT) && bus.rvalid && !stale_q && !redirect_i;

  // ==============================
  // Line request FSM
  // ==============================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q        <= `RESET_PC;
      state_q     <= FETCH_RUN;
      stale_q     <= 1'b0;
      req_q       <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      pc_q <= pc_d;
      case (state_q)
        FETCH_RUN: begin
          if (issue) begin
            req_q   <= 1'b1;
            state_q <= FETCH_REQ;
          end
        end
        FETCH_REQ: begin
          if (redirect_i) begin
            stale_q <= 1'b1;
          end
          if (bus.gnt) begin
            req_q   <= 1'b0;
            state_q <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (bus.rvalid) begin
            // Stale line is dropped and RUN asks again
            stale_q <= 1'b0;
            state_q <= FETCH_RUN;
            if (fill) begin
              buf_valid_q <= 1'b1;
            end
          end else if (redirect_i) begin
            stale_q <= 1'b1;
          end
        end
        default: state_q <= FETCH_RUN;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      req_addr_q <= {pc_d[`ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    end
    if (fill) begin
      buf_line_q <= bus.rdata;
      buf_tag_q  <= req_addr_q[`ADDR_W-1:OFF_W];
    end
  end

  // Fetch only reads lines
  assign bus.req   = req_q;
  assign bus.we    = 1'b0;
  assign bus.addr  = req_addr_q;
  assign bus.wdata = '0;

endmodule

//--- verilog/load_store_unit.sv
`timescale 1ns/10ps
`include "core_mem_consts.svh"

module load_store_unit import core_mem_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         lsu_req_i,
  input  logic         lsu_we_i,
  input  access_size_t lsu_size_i,
  input  addr_t        lsu_addr_i,
  input  word_t        lsu_wdata_i,
  output word_t        lsu_rdata_o,
  output logic         lsu_done_o,
  output logic         lsu_busy_o,
  mem_req_if.requester bus
);

  localparam int OFF_W = $clog2(`LINE_BYTES);

  lsu_state_t       state_q;
  logic             done_q;
  logic             we_q;
  access_size_t     size_q;
  addr_t            addr_q;
  word_t            wdata_q;
  word_t            rdata_q;
  line_t            line_q;
  word_t            size_mask;
  logic [OFF_W+2:0] shamt;
  line_t            rd_shifted;
  line_t            merged;

  // ==============================
  // Lane select and merge
  // ==============================
  assign shamt = {addr_q[OFF_W-1:0], 3'b000};

  always_comb begin
    case (size_q)
      SIZE_BYTE: size_mask = word_t'(8'hFF);
      SIZE_HALF: size_mask = word_t'(16'hFFFF);
      default:   size_mask = '1;
    endcase
    rd_shifted = bus.rdata >> shamt;
    merged     = (bus.rdata & ~(line_t'(size_mask) << shamt))
               | (line_t'(wdata_q & size_mask) << shamt);
  end

  // ==============================
  // Access FSM
  // ==============================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= LSU_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        LSU_IDLE: begin
          if (lsu_req_i) begin
            state_q <= LSU_RD_REQ;
          end
        end
        LSU_RD_REQ: begin
          if (bus.gnt) begin
            state_q <= LSU_RD_WAIT;
          end
        end
        LSU_RD_WAIT: begin
          if (bus.rvalid) begin
            if (we_q) begin
              state_q <= LSU_WR_REQ;
            end else begin
              done_q  <= 1'b1;
              state_q <= LSU_IDLE;
            end
          end
        end
        LSU_WR_REQ: begin
          if (bus.gnt) begin
            state_q <= LSU_WR_WAIT;
          end
        end
        LSU_WR_WAIT: begin
          if (bus.wdone) begin
            done_q  <= 1'b1;
            state_q <= LSU_IDLE;
          end
        end
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == LSU_IDLE && lsu_req_i) begin
      we_q    <= lsu_we_i;
      size_q  <= lsu_size_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
    if (state_q == LSU_RD_WAIT && bus.rvalid) begin
      if (we_q) begin
        line_q <= merged;
      end else begin
        // Zero-extended load result
        rdata_q <= rd_shifted[`WORD_W-1:0] & size_mask;
      end
    end
  end

  assign lsu_rdata_o = rdata_q;
  assign lsu_done_o  = done_q;
  assign lsu_busy_o  = (state_q != LSU_IDLE);

  assign bus.req   = (state_q == LSU_RD_REQ) || (state_q == LSU_WR_REQ);
  assign bus.we    = (state_q == LSU_WR_REQ);
  assign bus.addr  = {addr_q[`ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign bus.wdata = line_q;

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter import core_mem_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  mem_req_if.arbiter instr,
  mem_req_if.arbiter data,
  input  logic  mem_data_valid_i,
  input  line_t mem_data_i,
  input  logic  mem_write_done_i,
  output logic  rd_req_valid_o,
  output logic  wr_req_valid_o,
  output logic  req_is_instr_o,
  output addr_t req_address_o,
  output line_t wr_data_o
);

  arb_state_t state_q;
  logic       instr_gnt_q;
  logic       data_gnt_q;
  logic       wr_q;
  logic       xfer_done;

  assign xfer_done = wr_q ? mem_write_done_i : mem_data_valid_i;

  // ==============================
  // Owner selection
  // ==============================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q        <= ARB_IDLE;
      instr_gnt_q    <= 1'b0;
      data_gnt_q     <= 1'b0;
      wr_q           <= 1'b0;
      rd_req_valid_o <= 1'b0;
      wr_req_valid_o <= 1'b0;
      req_is_instr_o <= 1'b0;
    end else begin
      instr_gnt_q    <= 1'b0;
      data_gnt_q     <= 1'b0;
      rd_req_valid_o <= 1'b0;
      wr_req_valid_o <= 1'b0;
      req_is_instr_o <= 1'b0;
      case (state_q)
        ARB_IDLE: begin
          // Data side has priority
          if (data.req) begin
            state_q        <= ARB_DATA;
            data_gnt_q     <= 1'b1;
            wr_q           <= data.we;
            rd_req_valid_o <= !data.we;
            wr_req_valid_o <= data.we;
          end else if (instr.req) begin
            state_q        <= ARB_INSTR;
            instr_gnt_q    <= 1'b1;
            wr_q           <= instr.we;
            rd_req_valid_o <= !instr.we;
            wr_req_valid_o <= instr.we;
            req_is_instr_o <= !instr.we;
          end
        end
        ARB_INSTR, ARB_DATA: begin
          if (xfer_done) begin
            state_q <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ARB_IDLE) begin
      if (data.req) begin
        req_address_o <= data.addr;
        wr_data_o     <= data.wdata;
      end else if (instr.req) begin
        req_address_o <= instr.addr;
        wr_data_o     <= instr.wdata;
      end
    end
  end

  // ==============================
  // Completion routing
  // ==============================
  assign instr.gnt    = instr_gnt_q;
  assign instr.rdata  = mem_data_i;
  assign instr.rvalid = (state_q == ARB_INSTR) && !wr_q && mem_data_valid_i;
  assign instr.wdone  = (state_q == ARB_INSTR) && wr_q && mem_write_done_i;

  assign data.gnt     = data_gnt_q;
  assign data.rdata   = mem_data_i;
  assign data.rvalid  = (state_q == ARB_DATA) && !wr_q && mem_data_valid_i;
  assign data.wdone   = (state_q == ARB_DATA) && wr_q && mem_write_done_i;

endmodule

//--- verilog/core_mem_top.sv
`timescale 1ns/10ps

module core_mem_top import core_mem_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,

  // Fetch side
  input  logic         fetch_en_i,
  input  logic         redirect_i,
  input  addr_t        redirect_pc_i,
  output logic         instr_valid_o,
  output word_t        instr_o,
  output addr_t        instr_pc_o,

  // Data side
  input  logic         lsu_req_i,
  input  logic         lsu_we_i,
  input  access_size_t lsu_size_i,
  input  addr_t        lsu_addr_i,
  input  word_t        lsu_wdata_i,
  output word_t        lsu_rdata_o,
  output logic         lsu_done_o,
  output logic         lsu_busy_o,

  // External memory port
  output logic         rd_req_valid_o,
  output logic         wr_req_valid_o,
  output logic         req_is_instr_o,
  output addr_t        req_address_o,
  output line_t        wr_data_o,
  input  logic         mem_data_valid_i,
  input  line_t        mem_data_i,
  input  logic         mem_write_done_i
);

  mem_req_if instr_bus ();
  mem_req_if data_bus ();

  fetch_unit u_fetch (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_en_i    (fetch_en_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .bus           (instr_bus.requester)
  );

  load_store_unit u_lsu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .lsu_req_i   (lsu_req_i),
    .lsu_we_i    (lsu_we_i),
    .lsu_size_i  (lsu_size_i),
    .lsu_addr_i  (lsu_addr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .lsu_rdata_o (lsu_rdata_o),
    .lsu_done_o  (lsu_done_o),
    .lsu_busy_o  (lsu_busy_o),
    .bus         (data_bus.requester)
  );

  mem_arbiter u_arb (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .instr            (instr_bus.arbiter),
    .data             (data_bus.arbiter),
    .mem_data_valid_i (mem_data_valid_i),
    .mem_data_i       (mem_data_i),
    .mem_write_done_i (mem_write_done_i),
    .rd_req_valid_o   (rd_req_valid_o),
    .wr_req_valid_o   (wr_req_valid_o),
    .req_is_instr_o   (req_is_instr_o),
    .req_address_o    (req_address_o),
    .wr_data_o        (wr_data_o)
  );

endmodule

//--- tests/tb_core_mem.sv
`timescale 1ns/10ps
`include "core_mem_consts.svh"

module tb_core_mem import core_mem_pkg::*; ();

  localparam int HALF_PERIOD = 10;
  localparam int WAIT_LIMIT  = 200;
  localparam int NUM_LINES   = `MEM_BYTES / `LINE_BYTES;

  logic         clk_i;
  logic         rst_i;
  logic         fetch_en_i;
  logic         redirect_i;
  addr_t        redirect_pc_i;
  logic         instr_valid_o;
  word_t        instr_o;
  addr_t        instr_pc_o;
  logic         lsu_req_i;
  logic         lsu_we_i;
  access_size_t lsu_size_i;
  addr_t        lsu_addr_i;
  word_t        lsu_wdata_i;
  word_t        lsu_rdata_o;
  logic         lsu_done_o;
  logic         lsu_busy_o;
  logic         rd_req_valid_o;
  logic         wr_req_valid_o;
  logic         req_is_instr_o;
  addr_t        req_address_o;
  line_t        wr_data_o;
  logic         mem_data_valid_i;
  line_t        mem_data_i;
  logic         mem_write_done_i;

  // Reference bytes and the line storage the memory model serves
  logic [7:0] ref_bytes [`MEM_BYTES];
  line_t      mem_lines [NUM_LINES];
  int         instr_rd_count = 0;
  int         error_count    = 0;
  int         timeout_count  = 0;

  core_mem_top u_dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .fetch_en_i       (fetch_en_i),
    .redirect_i       (redirect_i),
    .redirect_pc_i    (redirect_pc_i),
    .instr_valid_o    (instr_valid_o),
    .instr_o          (instr_o),
    .instr_pc_o       (instr_pc_o),
    .lsu_req_i        (lsu_req_i),
    .lsu_we_i         (lsu_we_i),
    .lsu_size_i       (lsu_size_i),
    .lsu_addr_i       (lsu_addr_i),
    .lsu_wdata_i      (lsu_wdata_i),
    .lsu_rdata_o      (lsu_rdata_o),
    .lsu_done_o       (lsu_done_o),
    .lsu_busy_o       (lsu_busy_o),
    .rd_req_valid_o   (rd_req_valid_o),
    .wr_req_valid_o   (wr_req_valid_o),
    .req_is_instr_o   (req_is_instr_o),
    .req_address_o    (req_address_o),
    .wr_data_o        (wr_data_o),
    .mem_data_valid_i (mem_data_valid_i),
    .mem_data_i       (mem_data_i),
    .mem_write_done_i (mem_write_done_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  // ==============================
  // Reference memory
  // ==============================
  function automatic word_t init_word(input int a);
    logic [11:0] a12;
    a12 = a[11:0];
    return {~a12, 8'h96, a12};
  endfunction

  function automatic int size_bytes(input access_size_t s);
    case (s)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return 4;
    endcase
  endfunction

  // Little-endian, zero-extended
  function automatic word_t ref_value(input addr_t a, input int n);
    word_t w;
    int    k;
    w = '0;
    for (k = 0; k < n; k++) begin
      w[8*k +: 8] = ref_bytes[(a + k) % `MEM_BYTES];
    end
    return w;
  endfunction

  function automatic line_t line_from_ref(input int idx);
    line_t l;
    int    k;
    for (k = 0; k < `LINE_BYTES; k++) begin
      l[8*k +: 8] = ref_bytes[idx*`LINE_BYTES + k];
    end
    return l;
  endfunction

  task automatic init_memory();
    word_t w;
    int    a;
    int    k;
    for (a = 0; a < `MEM_BYTES; a += 4) begin
      w = init_word(a);
      for (k = 0; k < 4; k++) begin
        ref_bytes[a+k] = w[8*k +: 8];
      end
      mem_lines[a/`LINE_BYTES][32*((a/4)%4) +: 32] = w;
    end
  endtask

  // ==============================
  // Memory model
  // ==============================
  initial begin : mem_model
    int    delay;
    int    idx;
    line_t wr_line;
    void'($urandom(9));
    forever begin
      @(posedge clk_i);
      #2;
      idx = (req_address_o % `MEM_BYTES) / `LINE_BYTES;
      if (rd_req_valid_o) begin
        if (req_is_instr_o) begin
          instr_rd_count++;
        end
        delay = $urandom_range(4, 1);
        repeat (delay) @(posedge clk_i);
        #2;
        mem_data_i       = mem_lines[idx];
        mem_data_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        mem_data_valid_i = 1'b0;
      end else if (wr_req_valid_o) begin
        wr_line = wr_data_o;
        delay   = $urandom_range(4, 1);
        repeat (delay) @(posedge clk_i);
        #2;
        mem_lines[idx]   = wr_line;
        mem_write_done_i = 1'b1;
        @(posedge clk_i);
        #2;
        mem_write_done_i = 1'b0;
      end
    end
  end

  // ==============================
  // Compare and wait helpers
  // ==============================
  task automatic cmp_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic verify_flag(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic match_line(input string name, input line_t exp, input line_t act);
    assert (act === exp) else begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    timeout_count++;
  endtask

  task automatic wait_lsu_idle();
    int waited;
    waited = 0;
    while (lsu_busy_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    assert (!lsu_busy_o) else report_timeout("lsu_busy_o to fall");
  endtask

  task automatic wait_lsu_done();
    int waited;
    waited = 0;
    while (!lsu_done_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    assert (lsu_done_o) else report_timeout("lsu_done_o");
  endtask

  // Strobe of any owner, or only a fetch read
  task automatic wait_strobe(input bit instr_only);
    int   waited;
    logic seen;
    waited = 0;
    @(negedge clk_i);
    seen = (rd_req_valid_o || wr_req_valid_o) && (!instr_only || req_is_instr_o);
    while (!seen && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
      seen = (rd_req_valid_o || wr_req_valid_o) && (!instr_only || req_is_instr_o);
    end
    assert (seen) else report_timeout("an external memory strobe");
  endtask

  task automatic start_lsu(input logic we, input access_size_t size, input addr_t addr,
                           input word_t wdata);
    wait_lsu_idle();
    @(posedge clk_i);
    #2;
    lsu_req_i   = 1'b1;
    lsu_we_i    = we;
    lsu_size_i  = size;
    lsu_addr_i  = addr;
    lsu_wdata_i = wdata;
    @(posedge clk_i);
    #2;
    lsu_req_i = 1'b0;
  endtask

  task automatic load_and_compare(input addr_t addr, input access_size_t size);
    start_lsu(1'b0, size, addr, '0);
    wait_lsu_done();
    cmp_word("lsu_rdata_o", ref_value(addr, size_bytes(size)), lsu_rdata_o);
  endtask

  task automatic store_and_compare(input addr_t addr, input access_size_t size,
                                   input word_t data);
    int k;
    int idx;
    start_lsu(1'b1, size, addr, data);
    wait_lsu_done();
    for (k = 0; k < size_bytes(size); k++) begin
      ref_bytes[(addr + k) % `MEM_BYTES] = data[8*k +: 8];
    end
    // Neighbors in the line must be untouched
    idx = (addr % `MEM_BYTES) / `LINE_BYTES;
    match_line("memory line", line_from_ref(idx), mem_lines[idx]);
    load_and_compare(addr & ~32'h3, SIZE_WORD);
  endtask

  task automatic redirect_pc(input addr_t target);
    @(posedge clk_i);
    #2;
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    @(posedge clk_i);
    #2;
    redirect_i = 1'b0;
  endtask

  task automatic expect_stream(input addr_t start_pc, input int count);
    addr_t pc;
    int    waited;
    int    i;
    pc = start_pc;
    @(posedge clk_i);
    #2;
    fetch_en_i = 1'b1;
    for (i = 0; i < count; i++) begin
      waited = 0;
      @(negedge clk_i);
      while (!instr_valid_o && waited < WAIT_LIMIT) begin
        @(negedge clk_i);
        waited++;
      end
      assert (instr_valid_o) else report_timeout("instr_valid_o");
      if (!instr_valid_o) begin
        break;
      end
      cmp_word("instr_pc_o", pc, instr_pc_o);
      cmp_word("instr_o", ref_value(pc, 4), instr_o);
      pc = addr_t'((pc + 4) % `MEM_BYTES);
    end
    @(posedge clk_i);
    #2;
    fetch_en_i = 1'b0;
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic reset_outputs_low();
    @(posedge clk_i);
    @(negedge clk_i);
    verify_flag("instr_valid_o", 1'b0, instr_valid_o);
    verify_flag("lsu_done_o", 1'b0, lsu_done_o);
    verify_flag("lsu_busy_o", 1'b0, lsu_busy_o);
    verify_flag("rd_req_valid_o", 1'b0, rd_req_valid_o);
    verify_flag("wr_req_valid_o", 1'b0, wr_req_valid_o);
    verify_flag("req_is_instr_o", 1'b0, req_is_instr_o);
  endtask

  task automatic sequential_fetch();
    expect_stream(`RESET_PC, 11);
    cmp_word("instruction read strobes", 32'd3, instr_rd_count);
  endtask

  task automatic redirect_fetch();
    redirect_pc(32'h200);
    expect_stream(32'h200, 7);
    // Second redirect lands while the 0x400 line is in flight
    redirect_pc(32'h400);
    wait_strobe(1'b1);
    redirect_pc(32'h804);
    expect_stream(32'h804, 6);
  endtask

  task automatic sized_loads();
    load_and_compare(32'h100, SIZE_WORD);
    load_and_compare(32'h108, SIZE_HALF);
    load_and_compare(32'h10E, SIZE_HALF);
    load_and_compare(32'h101, SIZE_BYTE);
    load_and_compare(32'h10F, SIZE_BYTE);
    load_and_compare(32'h7FC, SIZE_WORD);
  endtask

  task automatic sized_stores();
    store_and_compare(32'h120, SIZE_WORD, 32'hDEAD_BEEF);
    store_and_compare(32'h126, SIZE_HALF, 32'h1234_CAFE);
    store_and_compare(32'h12B, SIZE_BYTE, 32'h0000_55AA);
    store_and_compare(32'h12C, SIZE_BYTE, 32'h0000_007F);
  endtask

  task automatic load_beats_fetch();
    wait_lsu_idle();
    @(posedge clk_i);
    #2;
    redirect_i    = 1'b1;
    redirect_pc_i = 32'h600;
    lsu_req_i     = 1'b1;
    lsu_we_i      = 1'b0;
    lsu_size_i    = SIZE_WORD;
    lsu_addr_i    = 32'h124;
    lsu_wdata_i   = '0;
    @(posedge clk_i);
    #2;
    redirect_i = 1'b0;
    lsu_req_i  = 1'b0;
    wait_strobe(1'b0);
    verify_flag("req_is_instr_o", 1'b0, req_is_instr_o);
    verify_flag("rd_req_valid_o", 1'b1, rd_req_valid_o);
    cmp_word("req_address_o", 32'h120, req_address_o);
    wait_lsu_done();
    cmp_word("lsu_rdata_o", ref_value(32'h124, 4), lsu_rdata_o);
    expect_stream(32'h600, 5);
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    rst_i            = 1'b0;
    fetch_en_i       = 1'b1;
    redirect_i       = 1'b0;
    redirect_pc_i    = '0;
    lsu_req_i        = 1'b0;
    lsu_we_i         = 1'b0;
    lsu_size_i       = SIZE_WORD;
    lsu_addr_i       = '0;
    lsu_wdata_i      = '0;
    mem_data_valid_i = 1'b0;
    mem_data_i       = '0;
    mem_write_done_i = 1'b0;
    init_memory();

    repeat (8) @(posedge clk_i);
    #2;
    rst_i = 1'b1;

    reset_outputs_low();
    sequential_fetch();
    redirect_fetch();
    sized_loads();
    sized_stores();
    load_beats_fetch();

    $display("Errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+verilog
verilog/core_mem_pkg.sv
verilog/mem_req_if.sv
verilog/fetch_unit.sv
verilog/load_store_unit.sv
verilog/mem_arbiter.sv
verilog/core_mem_top.sv
tests/tb_core_mem.sv

//--- Bender.yml
package:
  name: core_mem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_mem_pkg.sv
      - verilog/mem_req_if.sv
      - verilog/fetch_unit.sv
      - verilog/load_store_unit.sv
      - verilog/mem_arbiter.sv
      - verilog/core_mem_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_core_mem.sv
